/* common/int_params.svh */
`ifndef INT_PARAMS_SVH
`define INT_PARAMS_SVH

// issue queue entries
`define IQ_DEPTH 8
// physical integer registers
`define PREG_NUM 32
// datapath width
`define XLEN 32
// raw immediate width, sign-extended to XLEN
`define IMM_W 12

`endif

/* common/int_pkg.sv */
`include "int_params.svh"

package int_pkg;

    typedef logic [`XLEN-1:0] xdata_t;
    typedef logic [$clog2(`PREG_NUM)-1:0] preg_idx_t;
    typedef logic [$clog2(`IQ_DEPTH)-1:0] iq_idx_t;
    typedef logic [`IMM_W-1:0] imm_t;

    // alu operations, LI writes the sign-extended immediate
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6,
        ALU_SLT = 4'd7,
        ALU_LI  = 4'd8
    } alu_op_e;

    // micro-op as dispatched into the issue queue
    typedef struct packed {
        alu_op_e   op;
        logic      use_imm;
        preg_idx_t dst;
        preg_idx_t src1;
        preg_idx_t src2;
        imm_t      imm;
    } disp_uop_t;

    // issued micro-op with its operands resolved
    typedef struct packed {
        alu_op_e   op;
        preg_idx_t dst;
        xdata_t    a;
        xdata_t    b;
    } exe_uop_t;

    // one result, used for wakeup, bypass and writeback
    typedef struct packed {
        preg_idx_t dst;
        xdata_t    data;
    } wb_t;

endpackage

/* issue/preg_scoreboard.sv */
`timescale 1ns/100ps
`include "int_params.svh"

module preg_scoreboard import int_pkg::*; (
    input  logic      clk,
    input  logic      i_rst,
    input  logic      i_flush,
    input  logic      i_set_valid,
    input  preg_idx_t i_set_idx,
    input  logic      i_clr_valid,
    input  preg_idx_t i_clr_idx,
    input  preg_idx_t i_src1_idx,
    input  preg_idx_t i_src2_idx,
    output logic      o_src1_busy,
    output logic      o_src2_busy
);
    logic [`PREG_NUM-1:0] busy;

    // a wakeup in the lookup cycle already counts as ready
    assign o_src1_busy = busy[i_src1_idx] && !(i_clr_valid && (i_clr_idx == i_src1_idx));
    assign o_src2_busy = busy[i_src2_idx] && !(i_clr_valid && (i_clr_idx == i_src2_idx));

    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            busy <= '0;
        end else begin
            if (i_clr_valid) begin
                busy[i_clr_idx] <= 1'b0;
            end
            if (i_set_valid) begin
                busy[i_set_idx] <= 1'b1;
            end
        end
    end

    // every result broadcast belongs to a register that was marked at dispatch
    a_clr_was_busy: assert property (@(posedge clk) disable iff (i_rst)
        i_clr_valid |-> busy[i_clr_idx]);

endmodule

/* issue/issue_queue.sv */
`timescale 1ns/100ps
`include "int_params.svh"

module issue_queue import int_pkg::*; (
    input  logic      clk,
    input  logic      i_rst,
    input  logic      i_flush,
    input  logic      i_disp_valid,
    input  disp_uop_t i_disp_uop,
    output logic      o_disp_ready,
    input  logic      i_src1_busy,
    input  logic      i_src2_busy,
    output logic      o_issue_valid,
    output disp_uop_t o_issue_uop,
    input  logic      i_issue_ready,
    input  logic      i_wake_valid,
    input  wb_t       i_wake
);
    disp_uop_t            entry_uop [`IQ_DEPTH];
    logic [`IQ_DEPTH-1:0] entry_valid;
    logic [`IQ_DEPTH-1:0] src1_rdy;
    logic [`IQ_DEPTH-1:0] src2_rdy;
    logic [`IQ_DEPTH-1:0] entry_rdy;
    logic                 disp_en;
    logic                 full;
    logic                 enq;
    logic                 deq;
    iq_idx_t              free_idx;
    iq_idx_t              sel_idx;
    logic                 no_src1;
    logic                 no_src2;
    logic                 enq_src1_rdy;
    logic                 enq_src2_rdy;

    // held low through reset and open from the first cycle after
    always_ff @(posedge clk) begin
        if (i_rst) begin
            disp_en <= 1'b0;
        end else begin
            disp_en <= 1'b1;
        end
    end

    assign full         = &entry_valid;
    assign o_disp_ready = disp_en && !full && !i_flush;
    assign enq          = i_disp_valid && o_disp_ready;

    // LI reads no register and use_imm drops source 2
    assign no_src1 = (i_disp_uop.op == ALU_LI);
    assign no_src2 = i_disp_uop.use_imm || (i_disp_uop.op == ALU_LI);

    assign enq_src1_rdy = no_src1 || !i_src1_busy
                       || (i_wake_valid && (i_wake.dst == i_disp_uop.src1));
    assign enq_src2_rdy = no_src2 || !i_src2_busy
                       || (i_wake_valid && (i_wake.dst == i_disp_uop.src2));

    // lowest free slot for enqueue
    always_comb begin
        free_idx = '0;
        for (int i = `IQ_DEPTH - 1; i >= 0; i--) begin
            if (!entry_valid[i]) begin
                free_idx = iq_idx_t'(i);
            end
        end
    end

    assign entry_rdy = entry_valid & src1_rdy & src2_rdy;

    // lowest ready index wins
    always_comb begin
        sel_idx = '0;
        for (int i = `IQ_DEPTH - 1; i >= 0; i--) begin
            if (entry_rdy[i]) begin
                sel_idx = iq_idx_t'(i);
            end
        end
    end

    assign o_issue_valid = |entry_rdy;
    assign o_issue_uop   = entry_uop[sel_idx];
    assign deq           = o_issue_valid && i_issue_ready;

    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            entry_valid <= '0;
        end else begin
            if (deq) begin
                entry_valid[sel_idx] <= 1'b0;
            end
            if (enq) begin
                entry_valid[free_idx] <= 1'b1;
            end
        end
    end

    // wakeup compares every slot and a new entry overrides its own slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (i_wake_valid && (entry_uop[i].src1 == i_wake.dst)) begin
                src1_rdy[i] <= 1'b1;
            end
            if (i_wake_valid && (entry_uop[i].src2 == i_wake.dst)) begin
                src2_rdy[i] <= 1'b1;
            end
        end
        if (enq) begin
            entry_uop[free_idx] <= i_disp_uop;
            src1_rdy[free_idx]  <= enq_src1_rdy;
            src2_rdy[free_idx]  <= enq_src2_rdy;
        end
    end

    // the issued slot holds a live entry with both sources ready
    a_sel_ready: assert property (@(posedge clk) disable iff (i_rst)
        o_issue_valid |-> entry_valid[sel_idx] && src1_rdy[sel_idx] && src2_rdy[sel_idx]);

    // an accepted micro-op always finds an empty slot
    a_enq_free: assert property (@(posedge clk) disable iff (i_rst)
        enq |-> !entry_valid[free_idx]);

endmodule

/* execute/reg_read_bypass.sv */
`timescale 1ns/100ps
`include "int_params.svh"

module reg_read_bypass import int_pkg::*; (
    input  logic      clk,
    input  logic      i_rst,
    input  logic      i_flush,
    input  logic      i_issue_valid,
    input  disp_uop_t i_issue_uop,
    output logic      o_issue_ready,
    input  logic      i_wb_write,
    input  wb_t       i_wb,
    input  logic      i_byp_valid,
    input  wb_t       i_byp,
    output logic      o_exe_valid,
    output exe_uop_t  o_exe_uop,
    input  logic      i_exe_ready
);
    xdata_t    regfile [`PREG_NUM];
    logic      rs_valid;
    disp_uop_t rs_uop;
    xdata_t    rs_val1;
    xdata_t    rs_val2;
    logic      load;
    xdata_t    rd_val1;
    xdata_t    rd_val2;
    xdata_t    imm_ext;

    always_ff @(posedge clk) begin
        if (i_wb_write) begin
            regfile[i_wb.dst] <= i_wb.data;
        end
    end

    // pending result is newer than the array, also when it writes on this edge
    assign rd_val1 = (i_byp_valid && (i_byp.dst == i_issue_uop.src1))
                   ? i_byp.data : regfile[i_issue_uop.src1];
    assign rd_val2 = (i_byp_valid && (i_byp.dst == i_issue_uop.src2))
                   ? i_byp.data : regfile[i_issue_uop.src2];

    assign o_issue_ready = !rs_valid || i_exe_ready;
    assign load          = i_issue_valid && o_issue_ready;

    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            rs_valid <= 1'b0;
        end else if (o_issue_ready) begin
            rs_valid <= i_issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rs_uop  <= i_issue_uop;
            rs_val1 <= rd_val1;
            rs_val2 <= rd_val2;
        end
    end

    assign imm_ext = {{(`XLEN - `IMM_W){rs_uop.imm[`IMM_W-1]}}, rs_uop.imm};

    // operands, bypass first, immediate over source 2
    assign o_exe_valid   = rs_valid;
    assign o_exe_uop.op  = rs_uop.op;
    assign o_exe_uop.dst = rs_uop.dst;
    assign o_exe_uop.a   = (i_byp_valid && (i_byp.dst == rs_uop.src1)) ? i_byp.data : rs_val1;
    assign o_exe_uop.b   = (rs_uop.use_imm || (rs_uop.op == ALU_LI)) ? imm_ext
                         : (i_byp_valid && (i_byp.dst == rs_uop.src2)) ? i_byp.data : rs_val2;

endmodule

/* execute/int_alu.sv */
`timescale 1ns/100ps
`include "int_params.svh"

module int_alu import int_pkg::*; (
    input  logic     clk,
    input  logic     i_rst,
    input  logic     i_flush,
    input  logic     i_exe_valid,
    input  exe_uop_t i_exe_uop,
    output logic     o_exe_ready,
    output logic     o_wake_valid,
    output wb_t      o_wake,
    output logic     o_wb_valid,
    output wb_t      o_wb,
    input  logic     i_wb_ready
);
    localparam int SHAMT_W = $clog2(`XLEN);

    xdata_t               alu_res;
    logic                 load;
    logic [SHAMT_W-1:0]   shamt;
    logic                 lt_signed;

    assign shamt     = i_exe_uop.b[SHAMT_W-1:0];
    assign lt_signed = $signed(i_exe_uop.a) < $signed(i_exe_uop.b);

    always_comb begin
        case (i_exe_uop.op)
            ALU_ADD: alu_res = i_exe_uop.a + i_exe_uop.b;
            ALU_SUB: alu_res = i_exe_uop.a - i_exe_uop.b;
            ALU_AND: alu_res = i_exe_uop.a & i_exe_uop.b;
            ALU_OR:  alu_res = i_exe_uop.a | i_exe_uop.b;
            ALU_XOR: alu_res = i_exe_uop.a ^ i_exe_uop.b;
            ALU_SLL: alu_res = i_exe_uop.a << shamt;
            ALU_SRL: alu_res = i_exe_uop.a >> shamt;
            ALU_SLT: alu_res = {{(`XLEN - 1){1'b0}}, lt_signed};
            // operand b already holds the extended immediate
            ALU_LI:  alu_res = i_exe_uop.b;
            default: alu_res = '0;
        endcase
    end

    // result register empty or draining this cycle
    assign o_exe_ready = !o_wb_valid || i_wb_ready;
    assign load        = i_exe_valid && o_exe_ready;

    // wakeup goes out in the load cycle
    assign o_wake_valid = load;
    assign o_wake       = '{dst: i_exe_uop.dst, data: alu_res};

    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            o_wb_valid <= 1'b0;
        end else if (o_exe_ready) begin
            o_wb_valid <= i_exe_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            o_wb <= o_wake;
        end
    end

    // writeback payload held while stalled
    a_wb_hold: assert property (@(posedge clk) disable iff (i_rst)
        o_wb_valid && !i_wb_ready && !i_flush |=> o_wb_valid && $stable(o_wb));

endmodule

/* design/int_block_top.sv */
`timescale 1ns/100ps

module int_block_top import int_pkg::*; (
    input  logic      clk,
    input  logic      i_rst,
    input  logic      i_flush,
    input  logic      i_disp_valid,
    input  disp_uop_t i_disp_uop,
    output logic      o_disp_ready,
    output logic      o_wb_valid,
    output wb_t       o_wb,
    input  logic      i_wb_ready
);
    logic      disp_fire;
    logic      src1_busy;
    logic      src2_busy;
    logic      iss_valid;
    disp_uop_t iss_uop;
    logic      iss_ready;
    logic      exe_valid;
    exe_uop_t  exe_uop;
    logic      exe_ready;
    logic      wake_valid;
    wb_t       wake;
    logic      wb_write;

    assign disp_fire = i_disp_valid && o_disp_ready;
    assign wb_write  = o_wb_valid && i_wb_ready;

    preg_scoreboard scoreboard_i (
        .clk         ( clk               ),
        .i_rst       ( i_rst             ),
        .i_flush     ( i_flush           ),
        .i_set_valid ( disp_fire         ),
        .i_set_idx   ( i_disp_uop.dst    ),
        .i_clr_valid ( wake_valid        ),
        .i_clr_idx   ( wake.dst          ),
        .i_src1_idx  ( i_disp_uop.src1   ),
        .i_src2_idx  ( i_disp_uop.src2   ),
        .o_src1_busy ( src1_busy         ),
        .o_src2_busy ( src2_busy         )
    );

    issue_queue iq_i (
        .clk           ( clk          ),
        .i_rst         ( i_rst        ),
        .i_flush       ( i_flush      ),
        .i_disp_valid  ( i_disp_valid ),
        .i_disp_uop    ( i_disp_uop   ),
        .o_disp_ready  ( o_disp_ready ),
        .i_src1_busy   ( src1_busy    ),
        .i_src2_busy   ( src2_busy    ),
        .o_issue_valid ( iss_valid    ),
        .o_issue_uop   ( iss_uop      ),
        .i_issue_ready ( iss_ready    ),
        .i_wake_valid  ( wake_valid   ),
        .i_wake        ( wake         )
    );

    // pending alu result is both the write port and the bypass
    reg_read_bypass rr_i (
        .clk           ( clk        ),
        .i_rst         ( i_rst      ),
        .i_flush       ( i_flush    ),
        .i_issue_valid ( iss_valid  ),
        .i_issue_uop   ( iss_uop    ),
        .o_issue_ready ( iss_ready  ),
        .i_wb_write    ( wb_write   ),
        .i_wb          ( o_wb       ),
        .i_byp_valid   ( o_wb_valid ),
        .i_byp         ( o_wb       ),
        .o_exe_valid   ( exe_valid  ),
        .o_exe_uop     ( exe_uop    ),
        .i_exe_ready   ( exe_ready  )
    );

    int_alu alu_i (
        .clk          ( clk        ),
        .i_rst        ( i_rst      ),
        .i_flush      ( i_flush    ),
        .i_exe_valid  ( exe_valid  ),
        .i_exe_uop    ( exe_uop    ),
        .o_exe_ready  ( exe_ready  ),
        .o_wake_valid ( wake_valid ),
        .o_wake       ( wake       ),
        .o_wb_valid   ( o_wb_valid ),
        .o_wb         ( o_wb       ),
        .i_wb_ready   ( i_wb_ready )
    );

endmodule

/* sim/int_ref_model.svh */
`ifndef INT_REF_MODEL_SVH
`define INT_REF_MODEL_SVH

// register values in dispatch order, each result predicted from these
xdata_t spec_regs [`PREG_NUM];
// register values that have passed the writeback port
xdata_t commit_regs [`PREG_NUM];

// LI reads no register
function automatic logic reads_src1(input disp_uop_t uop);
    return uop.op != ALU_LI;
endfunction

// immediate takes the place of source 2
function automatic logic reads_src2(input disp_uop_t uop);
    return !uop.use_imm && (uop.op != ALU_LI);
endfunction

function automatic xdata_t expected_result(input disp_uop_t uop);
    xdata_t a;
    xdata_t b;
    xdata_t imm_val;
    imm_val = xdata_t'($signed(uop.imm));
    a       = spec_regs[uop.src1];
    b       = uop.use_imm ? imm_val : spec_regs[uop.src2];
    case (uop.op)
        ALU_ADD: return a + b;
        ALU_SUB: return a - b;
        ALU_AND: return a & b;
        ALU_OR:  return a | b;
        ALU_XOR: return a ^ b;
        ALU_SLL: return a << b[$clog2(`XLEN)-1:0];
        ALU_SRL: return a >> b[$clog2(`XLEN)-1:0];
        ALU_SLT: return xdata_t'($signed(a) < $signed(b));
        ALU_LI:  return imm_val;
        default: return '0;
    endcase
endfunction

// squashed results never reached the register file
function automatic void rollback_model();
    for (int i = 0; i < `PREG_NUM; i++) begin
        spec_regs[i] = commit_regs[i];
    end
endfunction

`endif

/* sim/tb_int_block.sv */
`timescale 1ns/100ps
`include "int_params.svh"

module tb_int_block import int_pkg::*; ();
    localparam int CLK_PERIOD  = 4;
    localparam int NUM_UOPS    = 220;
    localparam int WATCHDOG_NS = NUM_UOPS * 40 * CLK_PERIOD + 2000;
    localparam int SEED        = 7302;

    logic      clk;
    logic      i_rst;
    logic      i_flush;
    logic      i_disp_valid;
    disp_uop_t i_disp_uop;
    logic      o_disp_ready;
    logic      o_wb_valid;
    wb_t       o_wb;
    logic      i_wb_ready;

    // at most one result outstanding per destination
    logic [`PREG_NUM-1:0] exp_valid;
    xdata_t               exp_data [`PREG_NUM];
    disp_uop_t            exp_uop [`PREG_NUM];
    // outstanding micro-ops that still read each register
    int                   readers [`PREG_NUM];

    // 0 ready high, 1 ready low, 2 random
    int        wb_mode;
    int        errors;
    int        checks;
    int        errors_at_start;
    int        tests_run;
    int        tests_failed;
    int        disp_count;
    int        wb_count;
    int        squash_count;
    int        n_acc;
    logic      prev_stall;
    wb_t       prev_wb;
    logic      acc;
    disp_uop_t u;
    preg_idx_t last_dst;
    preg_idx_t li_dst;

    `include "int_ref_model.svh"

    int_block_top dut_i (
        .clk          ( clk          ),
        .i_rst        ( i_rst        ),
        .i_flush      ( i_flush      ),
        .i_disp_valid ( i_disp_valid ),
        .i_disp_uop   ( i_disp_uop   ),
        .o_disp_ready ( o_disp_ready ),
        .o_wb_valid   ( o_wb_valid   ),
        .o_wb         ( o_wb         ),
        .i_wb_ready   ( i_wb_ready   )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: writebacks still missing after %0d ns", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

    always @(negedge clk) begin
        case (wb_mode)
            0: i_wb_ready = 1'b1;
            1: i_wb_ready = 1'b0;
            default: i_wb_ready = ($urandom_range(0, 2) != 0);
        endcase
    end

    task automatic check_writeback(input wb_t wb);
        checks++;
        wb_count++;
        assert (exp_valid[wb.dst]) else begin
            $display("error at %0t: writeback to register %0d with no result outstanding",
                     $time, wb.dst);
            errors++;
        end
        if (exp_valid[wb.dst]) begin
            checks++;
            assert (wb.data == exp_data[wb.dst]) else begin
                $display("MISMATCH at %0t: register %0d got %h, expected %h",
                         $time, wb.dst, wb.data, exp_data[wb.dst]);
                errors++;
            end
            exp_valid[wb.dst]   = 1'b0;
            commit_regs[wb.dst] = exp_data[wb.dst];
            if (reads_src1(exp_uop[wb.dst])) begin
                readers[exp_uop[wb.dst].src1]--;
            end
            if (reads_src2(exp_uop[wb.dst])) begin
                readers[exp_uop[wb.dst].src2]--;
            end
        end
    endtask

    // compare process, every handshake and the hold rule while stalled
    always @(posedge clk) begin
        if (i_rst) begin
            prev_stall = 1'b0;
        end else begin
            if (prev_stall) begin
                checks++;
                assert (o_wb_valid && (o_wb == prev_wb)) else begin
                    $display("MISMATCH at %0t: stalled writeback %h changed to %h",
                             $time, prev_wb, o_wb);
                    errors++;
                end
            end
            if (o_wb_valid && i_wb_ready) begin
                check_writeback(o_wb);
            end
            prev_stall = o_wb_valid && !i_wb_ready && !i_flush;
            prev_wb    = o_wb;
        end
    end

    task automatic record_dispatch(input disp_uop_t du);
        exp_data[du.dst]  = expected_result(du);
        exp_uop[du.dst]   = du;
        exp_valid[du.dst] = 1'b1;
        spec_regs[du.dst] = exp_data[du.dst];
        if (reads_src1(du)) begin
            readers[du.src1]++;
        end
        if (reads_src2(du)) begin
            readers[du.src2]++;
        end
        disp_count++;
    endtask

    task automatic await_accept(input disp_uop_t du, input int max_wait, output logic ok);
        int waited;
        ok     = 1'b0;
        waited = 0;
        while (!ok && (waited < max_wait)) begin
            @(posedge clk);
            waited++;
            if (o_disp_ready) begin
                ok = 1'b1;
                record_dispatch(du);
            end
        end
    endtask

    task automatic send_uop(input disp_uop_t du, input int max_wait, output logic ok);
        @(negedge clk);
        i_disp_valid = 1'b1;
        i_disp_uop   = du;
        await_accept(du, max_wait, ok);
    endtask

    // free means no result outstanding and no outstanding reader
    task automatic pick_dst(output preg_idx_t d);
        int   start;
        int   r;
        logic found;
        found = 1'b0;
        d     = '0;
        while (!found) begin
            start = $urandom_range(0, `PREG_NUM - 1);
            for (int k = 0; k < `PREG_NUM; k++) begin
                r = (start + k) % `PREG_NUM;
                if (!found && !exp_valid[r] && (readers[r] == 0)) begin
                    d     = preg_idx_t'(r);
                    found = 1'b1;
                end
            end
            if (!found) begin
                @(negedge clk);
                i_disp_valid = 1'b0;
            end
        end
    endtask

    function automatic preg_idx_t random_src(input logic indep);
        preg_idx_t s;
        s = preg_idx_t'($urandom_range(0, `PREG_NUM - 1));
        while (indep && exp_valid[s]) begin
            s = preg_idx_t'($urandom_range(0, `PREG_NUM - 1));
        end
        return s;
    endfunction

    function automatic disp_uop_t li_uop(input preg_idx_t d);
        disp_uop_t nu;
        nu         = '0;
        nu.op      = ALU_LI;
        nu.use_imm = 1'b1;
        nu.dst     = d;
        nu.imm     = imm_t'($urandom);
        return nu;
    endfunction

    // chain reads the previous destination as source 1
    task automatic make_alu_uop(input logic chain, input logic indep, output disp_uop_t nu);
        preg_idx_t d;
        nu.op      = alu_op_e'($urandom_range(0, 7));
        nu.use_imm = ($urandom_range(0, 3) == 0);
        nu.src1    = chain ? last_dst : random_src(indep);
        nu.src2    = random_src(indep);
        nu.imm     = imm_t'($urandom);
        pick_dst(d);
        nu.dst     = d;
        last_dst   = d;
    endtask

    task automatic drain_all();
        @(negedge clk);
        i_disp_valid = 1'b0;
        do begin
            @(posedge clk);
        end while (exp_valid != '0);
    endtask

    task automatic squash_outstanding();
        for (int i = 0; i < `PREG_NUM; i++) begin
            if (exp_valid[i]) begin
                squash_count++;
            end
            readers[i] = 0;
        end
        exp_valid = '0;
        rollback_model();
    endtask

    task automatic close_test(input string name);
        int n_err;
        drain_all();
        checks++;
        assert (disp_count == wb_count + squash_count) else begin
            $display("error at %0t: %0d dispatched but %0d written back and %0d squashed",
                     $time, disp_count, wb_count, squash_count);
            errors++;
        end
        n_err = errors - errors_at_start;
        tests_run++;
        if (n_err != 0) begin
            tests_failed++;
        end
        $display("test %0d (%s): %s, %0d errors", tests_run, name,
                 (n_err == 0) ? "ok" : "failed", n_err);
        errors_at_start = errors;
    endtask

    initial begin
        void'($urandom(SEED));
        i_rst           = 1'b1;
        i_flush         = 1'b0;
        i_disp_valid    = 1'b0;
        i_disp_uop      = '0;
        i_wb_ready      = 1'b1;
        wb_mode         = 0;
        errors          = 0;
        checks          = 0;
        errors_at_start = 0;
        tests_run       = 0;
        tests_failed    = 0;
        disp_count      = 0;
        wb_count        = 0;
        squash_count    = 0;
        exp_valid       = '0;
        last_dst        = '0;
        for (int i = 0; i < `PREG_NUM; i++) begin
            readers[i] = 0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        i_rst = 1'b0;

        // every register gets a known value first
        for (int r = 0; r < `PREG_NUM; r++) begin
            send_uop(li_uop(preg_idx_t'(r)), 1000, acc);
        end
        drain_all();
        for (int n = 0; n < 40; n++) begin
            make_alu_uop(1'b0, 1'b1, u);
            send_uop(u, 1000, acc);
        end
        close_test("li and independent ops");

        for (int c = 0; c < 4; c++) begin
            last_dst = random_src(1'b1);
            for (int n = 0; n < 8; n++) begin
                make_alu_uop(1'b1, 1'b0, u);
                send_uop(u, 1000, acc);
            end
        end
        close_test("dependent chains");

        wb_mode = 2;
        for (int n = 0; n < 60; n++) begin
            make_alu_uop($urandom_range(0, 1), 1'b0, u);
            send_uop(u, 1000, acc);
        end
        close_test("random writeback ready");

        // alu result, read stage and every queue entry fill up
        wb_mode = 1;
        n_acc   = 0;
        acc     = 1'b1;
        while (acc && (n_acc < `IQ_DEPTH + 6)) begin
            make_alu_uop(1'b0, 1'b1, u);
            send_uop(u, 6, acc);
            if (acc) begin
                n_acc++;
            end
        end
        checks++;
        assert (!acc && (n_acc <= `IQ_DEPTH + 3)) else begin
            $display("error at %0t: dispatch still open after %0d acceptances", $time, n_acc);
            errors++;
        end
        wb_mode = 0;
        if (!acc) begin
            await_accept(u, 1000, acc);
        end
        close_test("full queue under stall");

        wb_mode  = 1;
        last_dst = random_src(1'b1);
        for (int n = 0; n < 6; n++) begin
            make_alu_uop(n % 2, 1'b0, u);
            send_uop(u, 1000, acc);
        end
        @(negedge clk);
        i_disp_valid = 1'b0;
        repeat (4) @(negedge clk);
        i_flush = 1'b1;
        @(posedge clk);
        squash_outstanding();
        @(negedge clk);
        i_flush = 1'b0;
        @(posedge clk);
        checks++;
        assert (o_disp_ready) else begin
            $display("error at %0t: dispatch not ready one cycle after flush", $time);
            errors++;
        end
        wb_mode = 0;
        // a writeback here would belong to a squashed micro-op
        repeat (20) @(posedge clk);
        for (int n = 0; n < 6; n++) begin
            pick_dst(li_dst);
            send_uop(li_uop(li_dst), 1000, acc);
        end
        for (int n = 0; n < 20; n++) begin
            make_alu_uop($urandom_range(0, 1), 1'b0, u);
            send_uop(u, 1000, acc);
        end
        close_test("flush and restart");

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+common
+incdir+sim
common/int_pkg.sv
issue/preg_scoreboard.sv
issue/issue_queue.sv
execute/reg_read_bypass.sv
execute/int_alu.sv
design/int_block_top.sv
sim/tb_int_block.sv

/* Bender.yml */
package:
  name: int_block

sources:
  - include_dirs:
      - common
    files:
      - common/int_pkg.sv
      - issue/preg_scoreboard.sv
      - issue/issue_queue.sv
      - execute/reg_read_bypass.sv
      - execute/int_alu.sv
      - design/int_block_top.sv
  - target: simulation
    include_dirs:
      - common
      - sim
    files:
      - sim/tb_int_block.sv
